// ==== include/datapath_consts.svh ====
`ifndef DATAPATH_CONSTS_SVH
`define DATAPATH_CONSTS_SVH

// ----------------------------------------------------------------------
// data path sizes
// ----------------------------------------------------------------------

// one bus word.
`define DATA_W 32

// general registers r0 to r15.
`define NUM_GPR 16

// ----------------------------------------------------------------------
// bus source selection
// ----------------------------------------------------------------------

`define NUM_SRC 24 // gprs, hi, lo, zhigh, zlow, pc, mdr, inport, c.
`define SEL_W 5

// no strobe raised, bus reads zero.
`define SEL_NONE 5'd31

`endif

// ==== design/datapath_pkg.sv ====
`default_nettype none

`include "datapath_consts.svh"

package datapath_pkg;

	typedef logic [`DATA_W-1:0] word_t;
	typedef logic [2*`DATA_W-1:0] dword_t; // product, or remainder and quotient.
	typedef logic [`SEL_W-1:0] bus_sel_t;
	typedef logic [`NUM_SRC-1:0] src_strobe_t; // bit order follows the mux codes.

	typedef enum logic [3:0]
	{
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_SHL = 4'd4,
		ALU_SHR = 4'd5,
		ALU_ROR = 4'd6,
		ALU_ROL = 4'd7,
		ALU_NEG = 4'd8,
		ALU_NOT = 4'd9,
		ALU_MUL = 4'd10,
		ALU_DIV = 4'd11
	} alu_op_t;

	// ------------------------------------------------------------------
	// control and bank bundles
	// ------------------------------------------------------------------

	typedef struct packed
	{
		logic [`NUM_GPR-1:0] r_in;
		logic hi_in;
		logic lo_in;
		logic pc_in;
		logic mdr_in;
		logic md_read; // mdr takes mem_data instead of the bus.
		logic y_in;
		logic z_in;
		logic outport_in;
	} load_t;

	typedef struct packed
	{
		src_strobe_t strobes;
		load_t load;
		alu_op_t alu_op;
	} ctrl_t;

	typedef struct packed
	{
		word_t [`NUM_GPR-1:0] gpr;
		word_t hi;
		word_t lo;
		word_t pc;
		word_t mdr;
		word_t inport;
	} bank_out_t;

endpackage

`default_nettype wire

// ==== design/bus_encoder.sv ====
`default_nettype none

`include "datapath_consts.svh"

module bus_encoder
	import datapath_pkg::*;
(
	input wire src_strobe_t strobes,
	output bus_sel_t bus_sel
);

	// ------------------------------------------------------------------
	// priority encode, lowest index wins
	// ------------------------------------------------------------------

	// scan from the top so a lower set bit overwrites a higher one.
	always_comb
	begin
		bus_sel = `SEL_NONE;
		for (int i = `NUM_SRC - 1; i >= 0; i--)
		begin
			if (strobes[i])
			begin
				bus_sel = bus_sel_t'(i);
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/bus_mux.sv ====
`default_nettype none

module bus_mux
	import datapath_pkg::*;
(
	input wire bus_sel_t bus_sel,
	input wire bank_out_t bank,
	input wire word_t zhigh,
	input wire word_t zlow,
	input wire word_t c_sign_extended,
	output word_t bus
);

	// ------------------------------------------------------------------
	// source codes
	// ------------------------------------------------------------------
	//  0..15  r0..r15
	//  16 hi, 17 lo, 18 zhigh, 19 zlow
	//  20 pc, 21 mdr, 22 inport, 23 c
	//  24..31 read as zero

	always_comb
	begin
		if (bus_sel[4] == 1'b0)
		begin
			bus = bank.gpr[bus_sel[3:0]]; // general registers.
		end
		else
		begin
			case (bus_sel)
				5'd16:
					bus = bank.hi;
				5'd17:
					bus = bank.lo;
				5'd18:
					bus = zhigh;
				5'd19:
					bus = zlow;
				5'd20:
					bus = bank.pc;
				5'd21:
					bus = bank.mdr;
				5'd22:
					bus = bank.inport;
				5'd23:
					bus = c_sign_extended;
				default:
					bus = '0; // unused codes.
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/register_bank.sv ====
`default_nettype none

`include "datapath_consts.svh"

module register_bank
	import datapath_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire word_t bus,
	input wire load_t load,
	input wire word_t mem_data,
	input wire word_t inport_data,
	output bank_out_t bank,
	output word_t outport_data
);

	word_t [`NUM_GPR-1:0] gpr_q;
	word_t hi_q;
	word_t lo_q;
	word_t pc_q;
	word_t mdr_q;
	word_t inport_q;
	word_t outport_q;

	// ------------------------------------------------------------------
	// general registers
	// ------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			gpr_q <= '0;
		end
		else
		begin
			for (int i = 0; i < `NUM_GPR; i++)
			begin
				if (load.r_in[i])
				begin
					gpr_q[i] <= bus;
				end
			end
		end
	end

	// ------------------------------------------------------------------
	// hi, lo, pc and mdr
	// ------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			hi_q <= '0;
			lo_q <= '0;
			pc_q <= '0;
		end
		else
		begin
			if (load.hi_in)
				hi_q <= bus;
			if (load.lo_in)
				lo_q <= bus;
			if (load.pc_in)
				pc_q <= bus;
		end
	end

	// memory read data or bus write.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			mdr_q <= '0;
		else if (load.mdr_in)
			mdr_q <= load.md_read ? mem_data : bus;
	end

	// ------------------------------------------------------------------
	// i/o ports
	// ------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			inport_q <= '0;
			outport_q <= '0;
		end
		else
		begin
			inport_q <= inport_data; // sampled every edge.
			if (load.outport_in)
				outport_q <= bus;
		end
	end

	assign bank.gpr = gpr_q;
	assign bank.hi = hi_q;
	assign bank.lo = lo_q;
	assign bank.pc = pc_q;
	assign bank.mdr = mdr_q;
	assign bank.inport = inport_q;
	assign outport_data = outport_q;

endmodule

`default_nettype wire

// ==== design/alu_unit.sv ====
`default_nettype none

`include "datapath_consts.svh"

module alu_unit
	import datapath_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire word_t bus,
	input wire y_in,
	input wire z_in,
	input wire alu_op_t alu_op,
	output word_t zhigh,
	output word_t zlow
);

	word_t y_q;
	dword_t z_q;
	word_t res_hi;
	word_t res_lo;
	logic [$clog2(`DATA_W)-1:0] shamt;
	dword_t rot_src;
	dword_t rot_r;
	dword_t rot_l;
	dword_t product;

	// ------------------------------------------------------------------
	// operand y
	// ------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			y_q <= '0;
		else if (y_in)
			y_q <= bus;
	end

	// ------------------------------------------------------------------
	// result of y with the bus
	// ------------------------------------------------------------------

	assign shamt = bus[$clog2(`DATA_W)-1:0];
	assign rot_src = {y_q, y_q}; // doubled word makes rotates plain shifts.
	assign rot_r = rot_src >> shamt;
	assign rot_l = rot_src << shamt;
	assign product = dword_t'(y_q) * dword_t'(bus);

	always_comb
	begin
		res_hi = '0;
		res_lo = '0;
		case (alu_op)
			ALU_ADD:
				res_lo = y_q + bus;
			ALU_SUB:
				res_lo = y_q - bus;
			ALU_AND:
				res_lo = y_q & bus;
			ALU_OR:
				res_lo = y_q | bus;
			ALU_SHL:
				res_lo = y_q << shamt;
			ALU_SHR:
				res_lo = y_q >> shamt; // logical.
			ALU_ROR:
				res_lo = rot_r[`DATA_W-1:0];
			ALU_ROL:
				res_lo = rot_l[2*`DATA_W-1:`DATA_W];
			ALU_NEG:
				res_lo = -bus;
			ALU_NOT:
				res_lo = ~bus;
			ALU_MUL:
			begin
				res_hi = product[2*`DATA_W-1:`DATA_W];
				res_lo = product[`DATA_W-1:0];
			end
			ALU_DIV:
			begin
				// divide by zero returns all ones and the dividend.
				if (bus == '0)
				begin
					res_hi = y_q;
					res_lo = '1;
				end
				else
				begin
					res_hi = y_q % bus;
					res_lo = y_q / bus;
				end
			end
			default:
				res_lo = '0;
		endcase
	end

	// ------------------------------------------------------------------
	// z register
	// ------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			z_q <= '0;
		else if (z_in)
			z_q <= {res_hi, res_lo};
	end

	assign zhigh = z_q[2*`DATA_W-1:`DATA_W];
	assign zlow = z_q[`DATA_W-1:0];

endmodule

`default_nettype wire

// ==== design/datapath_top.sv ====
`default_nettype none

module datapath_top
	import datapath_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire ctrl_t ctrl,
	input wire word_t mem_data,
	input wire word_t inport_data,
	input wire word_t c_sign_extended,
	output word_t bus,
	output word_t outport_data
);

	bus_sel_t bus_sel;
	bank_out_t bank_out;
	word_t zhigh;
	word_t zlow;

	// ------------------------------------------------------------------
	// bus source select and multiplexer
	// ------------------------------------------------------------------

	bus_encoder u_bus_encoder
	(
		.strobes (ctrl.strobes),
		.bus_sel (bus_sel)
	);

	bus_mux u_bus_mux
	(
		.bus_sel         (bus_sel),
		.bank            (bank_out),
		.zhigh           (zhigh),
		.zlow            (zlow),
		.c_sign_extended (c_sign_extended),
		.bus             (bus)
	);

	// ------------------------------------------------------------------
	// registers and alu
	// ------------------------------------------------------------------

	register_bank u_register_bank
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.bus          (bus),
		.load         (ctrl.load),
		.mem_data     (mem_data),
		.inport_data  (inport_data),
		.bank         (bank_out),
		.outport_data (outport_data)
	);

	alu_unit u_alu_unit
	(
		.clk    (clk),
		.rst_n  (rst_n),
		.bus    (bus),
		.y_in   (ctrl.load.y_in),
		.z_in   (ctrl.load.z_in),
		.alu_op (ctrl.alu_op),
		.zhigh  (zhigh),
		.zlow   (zlow)
	);

endmodule

`default_nettype wire

// ==== verif/datapath_tb.sv ====
`default_nettype none

`include "datapath_consts.svh"

module datapath_tb
	import datapath_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed
	{
		ctrl_t ctrl;
		word_t inport;
		word_t mem;
		word_t c;
		word_t exp_bus;
		word_t exp_out; // outport_data during the row's cycle.
	} row_t;

	logic clk = 1'b0;
	logic rst_n;
	ctrl_t ctrl;
	word_t mem_data;
	word_t inport_data;
	word_t c_sign_extended;
	word_t bus;
	word_t outport_data;

	row_t rows[$];
	word_t gpr_val [`NUM_GPR];
	word_t cur_inport;
	word_t cur_mem;
	word_t cur_c;
	word_t cur_out;
	word_t lcg_state;
	int errors;
	int checks;

	datapath_top dut0
	(
		.clk             (clk),
		.rst_n           (rst_n),
		.ctrl            (ctrl),
		.mem_data        (mem_data),
		.inport_data     (inport_data),
		.c_sign_extended (c_sign_extended),
		.bus             (bus),
		.outport_data    (outport_data)
	);

	always #2 clk = ~clk;

	initial
	begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------

	function automatic word_t lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic src_strobe_t strobe(input int idx);
		src_strobe_t s;
		s = '0;
		s[idx] = 1'b1;
		return s;
	endfunction

	task automatic check_value(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic add_row(input src_strobe_t s, input load_t l, input alu_op_t op,
		input word_t exp_bus);
		row_t r;
		r.ctrl.strobes = s;
		r.ctrl.load = l;
		r.ctrl.alu_op = op;
		r.inport = cur_inport;
		r.mem = cur_mem;
		r.c = cur_c;
		r.exp_bus = exp_bus;
		r.exp_out = cur_out;
		rows.push_back(r);
		if (l.outport_in)
			cur_out = exp_bus; // visible from the next row on.
	endtask

	// inport takes a cycle, then the bus carries it into the target.
	task automatic load_via_inport(input load_t l, input int src, input word_t v);
		cur_inport = v;
		add_row('0, '0, ALU_ADD, '0);
		add_row(strobe(22), l, ALU_ADD, v);
		add_row(strobe(src), '0, ALU_ADD, v);
	endtask

	// ----------------------------------------------------------------------
	// table construction
	// ----------------------------------------------------------------------

	task automatic write_rows();
		load_t l;
		word_t v;
		for (int i = 0; i < `NUM_GPR; i++)
		begin
			v = lcg_next();
			l = '0;
			l.r_in[i] = 1'b1;
			load_via_inport(l, i, v);
			gpr_val[i] = v;
		end
		l = '0;
		l.hi_in = 1'b1;
		load_via_inport(l, 16, lcg_next());
		l = '0;
		l.lo_in = 1'b1;
		load_via_inport(l, 17, lcg_next());
		l = '0;
		l.pc_in = 1'b1;
		load_via_inport(l, 20, lcg_next());
		v = lcg_next();
		cur_mem = v; // mdr from memory.
		l = '0;
		l.mdr_in = 1'b1;
		l.md_read = 1'b1;
		add_row('0, l, ALU_ADD, '0);
		add_row(strobe(21), '0, ALU_ADD, v);
		v = lcg_next();
		cur_c = v;
		add_row(strobe(23), '0, ALU_ADD, v);
		l.md_read = 1'b0; // mdr from the bus this time.
		add_row(strobe(23), l, ALU_ADD, v);
		add_row(strobe(21), '0, ALU_ADD, v);
		cur_c = '0;
	endtask

	// y from c, then z from y and c, then read both halves of z.
	task automatic alu_case(input alu_op_t op, input word_t a, input word_t b,
		input word_t exp_hi, input word_t exp_lo);
		load_t l;
		l = '0;
		l.y_in = 1'b1;
		cur_c = a;
		add_row(strobe(23), l, ALU_ADD, a);
		l = '0;
		l.z_in = 1'b1;
		cur_c = b;
		add_row(strobe(23), l, op, b);
		cur_c = '0;
		add_row(strobe(19), '0, ALU_ADD, exp_lo);
		add_row(strobe(18), '0, ALU_ADD, exp_hi);
	endtask

	task automatic alu_rows();
		word_t a;
		word_t b;
		word_t d;
		logic [4:0] s;
		dword_t p;
		a = lcg_next();
		b = lcg_next();
		a[31] = 1'b1; // tells a logical shr from an arithmetic one.
		b[0] = 1'b1; // odd, so the shift amount is never zero.
		s = b[4:0];
		// two-word results first so zhigh is nonzero before the one-word ops.
		p = {32'd0, a} * {32'd0, b};
		alu_case(ALU_MUL, a, b, p[63:32], p[31:0]);
		alu_case(ALU_DIV, a, b, a % b, a / b);
		d = b >> 20; // small divisor gives a larger quotient.
		alu_case(ALU_DIV, a, d, a % d, a / d);
		alu_case(ALU_DIV, a, '0, a, '1);
		alu_case(ALU_ADD, a, b, '0, a + b);
		alu_case(ALU_SUB, a, b, '0, a - b);
		alu_case(ALU_AND, a, b, '0, a & b);
		alu_case(ALU_OR, a, b, '0, a | b);
		alu_case(ALU_SHL, a, b, '0, a << s);
		alu_case(ALU_SHR, a, b, '0, a >> s);
		alu_case(ALU_ROR, a, b, '0, (a >> s) | (a << (6'd32 - {1'b0, s})));
		alu_case(ALU_ROL, a, b, '0, (a << s) | (a >> (6'd32 - {1'b0, s})));
		alu_case(ALU_NEG, a, b, '0, ~b + 32'd1);
		alu_case(ALU_NOT, a, b, '0, ~b);
	endtask

	task automatic build_table();
		load_t l;
		for (int i = 0; i < `NUM_SRC; i++)
			add_row(strobe(i), '0, ALU_ADD, '0); // all sources zero after reset.
		write_rows();
		alu_rows();
		add_row('0, '0, ALU_ADD, '0);
		add_row(strobe(3) | strobe(17), '0, ALU_ADD, gpr_val[3]);
		add_row(strobe(9) | strobe(12) | strobe(23), '0, ALU_ADD, gpr_val[9]);
		l = '0;
		l.outport_in = 1'b1;
		add_row(strobe(5), l, ALU_ADD, gpr_val[5]);
		for (int i = 0; i < 3; i++)
			add_row(strobe(i), '0, ALU_ADD, gpr_val[i]);
	endtask

	// ----------------------------------------------------------------------
	// run
	// ----------------------------------------------------------------------

	task automatic wait_reset_release(output bit timed_out);
		int cycles;
		cycles = 0;
		while (rst_n !== 1'b1 && cycles < 20)
		begin
			@(posedge clk);
			cycles++;
		end
		timed_out = (rst_n !== 1'b1);
	endtask

	task automatic apply_rows();
		foreach (rows[i])
		begin
			@(posedge clk);
			#1;
			ctrl = rows[i].ctrl;
			inport_data = rows[i].inport;
			mem_data = rows[i].mem;
			c_sign_extended = rows[i].c;
			#2; // one ns before the next edge.
			check_value($sformatf("bus (row %0d)", i), bus, rows[i].exp_bus);
			check_value($sformatf("outport_data (row %0d)", i), outport_data,
				rows[i].exp_out);
		end
	endtask

	initial
	begin
		bit timed_out;
		ctrl = '0;
		mem_data = '0;
		inport_data = '0;
		c_sign_extended = '0;
		errors = 0;
		checks = 0;
		lcg_state = 32'ha6c73296;
		cur_inport = '0;
		cur_mem = '0;
		cur_c = '0;
		cur_out = '0;
		for (int i = 0; i < `NUM_GPR; i++)
			gpr_val[i] = '0;
		build_table();
		wait_reset_release(timed_out);
		if (timed_out)
		begin
			errors++;
			$display("reset was not released within 20 clock cycles");
		end
		else
			apply_rows();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
design/datapath_pkg.sv
design/bus_encoder.sv
design/bus_mux.sv
design/register_bank.sv
design/alu_unit.sv
design/datapath_top.sv
verif/datapath_tb.sv

// ==== Makefile ====
TOP = datapath_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f project.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
